// File: bench/tick_timer_cases.svh
// stimulus table for the tick timer testbench, included inside the testbench module
// expected counts follow the timer rules: first strobe divisor+2 cycles into a
// restarted window, then one every divisor+1, and one expiry per limit+1 strobes
`ifndef TICK_TIMER_CASES_SVH
`define TICK_TIMER_CASES_SVH

// columns: name, divisor, limit, mode, enable, restart, cycles,
//          expected strobes, expected expiries, expected final done
task automatic fill_case_table();
   // divisor 0 keeps the strobe high every cycle
   add_case("div0_periodic", 0, 3, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b1, 40, 39, 9, 1'b0);
   add_case("div1_periodic", 1, 2, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b1, 40, 19, 6, 1'b0);
   // one-shot stops after the third strobe
   add_case("div5_oneshot", 5, 2, tick_timer_pkg::TMR_ONESHOT,
            1'b1, 1'b1, 60, 9, 1, 1'b1);
   // no restart, done must hold while strobes keep coming
   add_case("oneshot_hold", 5, 2, tick_timer_pkg::TMR_ONESHOT,
            1'b1, 1'b0, 30, 5, 0, 1'b1);
   // widest divisor, every strobe expires with limit 0
   add_case("div255_periodic", 255, 0, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b1, 600, 2, 2, 1'b0);
   // base phase for the divisor change that follows
   add_case("change_base", 3, 2, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b1, 20, 4, 1, 1'b0);
   // 3 -> 6 mid-run, gaps of 4 then only 7
   add_case("div_change", 6, 2, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b0, 30, 4, 2, 1'b0);
   // count sits at 1 with enable low
   add_case("enable_low", 6, 2, tick_timer_pkg::TMR_PERIODIC,
            1'b0, 1'b0, 20, 3, 0, 1'b0);
   // restart brings the held count back to zero
   add_case("restart_after", 2, 1, tick_timer_pkg::TMR_PERIODIC,
            1'b1, 1'b1, 24, 7, 3, 1'b0);
endtask

`endif

// File: bench/tick_timer_tb.sv
// testbench for the tick timer, applies a table of divisor, limit and mode cases
// and follows the DUT with a cycle model of the tick counter and strobe spacing
`timescale 1ns/1ns
`default_nettype none

module tick_timer_tb;

   localparam int DIV_WIDTH = 8;
   localparam int CNT_WIDTH = 8;
   localparam int MAX_CASES = 16;

   logic                          clk_i;
   logic                          rst_n_i;
   logic [DIV_WIDTH-1:0]          divisor_i;
   logic [CNT_WIDTH-1:0]          limit_i;
   tick_timer_pkg::timer_ctrl_t   ctrl_i;
   logic                          restart_i;
   logic                          strobe_o;
   logic [CNT_WIDTH-1:0]          count_o;
   logic                          expire_o;
   logic                          done_o;

   // case table
   string                         name_tbl    [MAX_CASES];
   int                            div_tbl     [MAX_CASES];
   int                            limit_tbl   [MAX_CASES];
   tick_timer_pkg::timer_mode_e   mode_tbl    [MAX_CASES];
   bit                            en_tbl      [MAX_CASES];
   bit                            restart_tbl [MAX_CASES];
   int                            cycles_tbl  [MAX_CASES];
   int                            strobes_tbl [MAX_CASES];
   int                            expires_tbl [MAX_CASES];
   bit                            done_tbl    [MAX_CASES];
   int                            num_cases = 0;

   // strobe spacing tracker
   int    cyc_idx = 0;
   int    last_strobe = 0;
   bit    have_prev = 1'b0;
   int    gap_old = 0;
   int    gap_new = 0;
   bit    new_seen = 1'b0;

   // counter model, cfg_* mirror the registered config inside the DUT
   int    m_count = 0;
   bit    m_expire = 1'b0;
   bit    m_done = 1'b0;
   bit    cfg_restart = 1'b1;
   bit    cfg_en = 1'b0;
   bit    cfg_oneshot = 1'b0;
   int    cfg_limit = 0;

   // per-case window totals
   bit    in_window = 1'b0;
   int    win_strobes = 0;
   int    win_expires = 0;
   logic  seen_done;
   string cur_name = "reset";

   int     cycle_count = 0;
   int     timeout_limit = 0;
   integer seed = 32'hb8aa_3e8e;
   int     i;
   int     rand_div;
   int     rand_cycles;

   tick_timer_top
   #(
      .DIV_WIDTH (DIV_WIDTH),
      .CNT_WIDTH (CNT_WIDTH)
   )
   tick_timer_top_inst
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .divisor_i (divisor_i),
      .limit_i   (limit_i),
      .ctrl_i    (ctrl_i),
      .restart_i (restart_i),
      .strobe_o  (strobe_o),
      .count_o   (count_o),
      .expire_o  (expire_o),
      .done_o    (done_o)
   );

   // 8 ns clock
   always #4 clk_i = ~clk_i;

   // watchdog on total cycles
   always @(posedge clk_i)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > timeout_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
         $display("Test failed");
         $fatal(1, "simulation stopped by the watchdog");
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
         $display("Test failed");
         $fatal(1, "simulation stopped at the first mismatch");
      end
   endtask

   task automatic add_case(input string name, input int div, input int limit,
                           input tick_timer_pkg::timer_mode_e mode, input bit en,
                           input bit restart, input int cycles, input int strobes,
                           input int expires, input bit done);
      name_tbl[num_cases]    = name;
      div_tbl[num_cases]     = div;
      limit_tbl[num_cases]   = limit;
      mode_tbl[num_cases]    = mode;
      en_tbl[num_cases]      = en;
      restart_tbl[num_cases] = restart;
      cycles_tbl[num_cases]  = cycles;
      strobes_tbl[num_cases] = strobes;
      expires_tbl[num_cases] = expires;
      done_tbl[num_cases]    = done;
      num_cases = num_cases + 1;
   endtask

   `include "tick_timer_cases.svh"

   // strobes seen in a restarted window of the given length
   // first one divisor+2 cycles in, then every divisor+1
   function automatic int strobes_within(input int div, input int cycles);
      if (cycles < div + 2)
         return 0;
      return (cycles - div - 2) / (div + 1) + 1;
   endfunction

   // one stable sample per cycle, then step the model to the next cycle
   task automatic observe_cycle();
      int gap;
      cyc_idx = cyc_idx + 1;
      seen_done = done_o;
      check_value({cur_name, " count"}, m_count, count_o);
      check_value({cur_name, " expire"}, m_expire, expire_o);
      check_value({cur_name, " done"}, m_done, done_o);
      if (strobe_o === 1'b1)
      begin
         if (have_prev)
         begin
            gap = cyc_idx - last_strobe;
            // old length only until the first gap of the new length
            if (gap == gap_new)
               new_seen = 1'b1;
            else if (!(gap == gap_old && !new_seen))
               check_value({cur_name, " gap"}, gap_new, gap);
         end
         have_prev   = 1'b1;
         last_strobe = cyc_idx;
         if (in_window)
            win_strobes = win_strobes + 1;
      end
      if (in_window && expire_o === 1'b1)
         win_expires = win_expires + 1;
      // counter state after the coming edge
      if (cfg_restart)
      begin
         m_count  = 0;
         m_expire = 1'b0;
         m_done   = 1'b0;
      end
      else
      begin
         m_expire = 1'b0;
         if (strobe_o === 1'b1 && cfg_en && !m_done)
         begin
            if (m_count == cfg_limit)
            begin
               m_count  = 0;
               m_expire = 1'b1;
               if (cfg_oneshot)
                  m_done = 1'b1;
            end
            else
            begin
               m_count = m_count + 1;
            end
         end
      end
      // inputs now on the pins are what the config stage holds next cycle
      cfg_restart = restart_i;
      cfg_en      = ctrl_i.enable;
      cfg_oneshot = (ctrl_i.mode == tick_timer_pkg::TMR_ONESHOT);
      cfg_limit   = limit_i;
   endtask

   task automatic tick();
      @(negedge clk_i);
      observe_cycle();
      @(posedge clk_i);
   endtask

   task automatic run_case(input int idx);
      tick_timer_pkg::timer_ctrl_t ctrl_nxt;
      int j;
      cur_name        = name_tbl[idx];
      ctrl_nxt.enable = en_tbl[idx];
      ctrl_nxt.mode   = mode_tbl[idx];
      divisor_i <= DIV_WIDTH'(div_tbl[idx]);
      limit_i   <= CNT_WIDTH'(limit_tbl[idx]);
      ctrl_i    <= ctrl_nxt;
      restart_i <= restart_tbl[idx];
      tick();
      restart_i <= 1'b0;
      tick();
      // window opens on the edge where a restart reloads the generator
      if (restart_tbl[idx])
      begin
         have_prev = 1'b0;
         gap_old   = div_tbl[idx] + 1;
      end
      else
      begin
         gap_old = gap_new;
      end
      gap_new     = div_tbl[idx] + 1;
      new_seen    = 1'b0;
      win_strobes = 0;
      win_expires = 0;
      in_window   = 1'b1;
      for (j = 0; j < cycles_tbl[idx]; j++)
         tick();
      in_window = 1'b0;
      check_value({cur_name, " strobes"}, strobes_tbl[idx], win_strobes);
      check_value({cur_name, " expires"}, expires_tbl[idx], win_expires);
      check_value({cur_name, " final done"}, done_tbl[idx], seen_done);
   endtask

   initial
   begin
      clk_i     = 1'b0;
      rst_n_i   = 1'b0;
      divisor_i = '0;
      limit_i   = '0;
      ctrl_i    = '0;
      restart_i = 1'b0;
      fill_case_table();
      // extra row with a random divisor, expected values from the timing rules
      rand_div    = $random(seed) & 32'hff;
      rand_cycles = 3 * (rand_div + 1) + 12;
      add_case("random_div", rand_div, 1, tick_timer_pkg::TMR_PERIODIC, 1'b1, 1'b1,
               rand_cycles, strobes_within(rand_div, rand_cycles),
               strobes_within(rand_div, rand_cycles - 1) / 2, 1'b0);
      // reset, two setup cycles per row, run lengths and some slack
      timeout_limit = 4 + 50;
      for (i = 0; i < num_cases; i++)
         timeout_limit = timeout_limit + cycles_tbl[i] + 2;
      // everything quiet while in reset
      repeat (4)
      begin
         @(posedge clk_i);
         @(negedge clk_i);
         check_value("reset strobe", 0, strobe_o);
         check_value("reset expire", 0, expire_o);
         check_value("reset done", 0, done_o);
         check_value("reset count", 0, count_o);
      end
      @(posedge clk_i);
      rst_n_i <= 1'b1;
      for (i = 0; i < num_cases; i++)
         run_case(i);
      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: common/tick_timer_pkg.sv
// shared types for the tick timer pipeline
// stages refer to these by scoped name, e.g. tick_timer_pkg::timer_ctrl_t
`default_nettype none

package tick_timer_pkg;

   // how the tick counter behaves once it reaches the limit
   typedef enum logic
   {
      // wrap to zero and keep counting
      TMR_PERIODIC = 1'b0,
      // stop after the first expiry until restarted
      TMR_ONESHOT  = 1'b1
   } timer_mode_e;

   // control bits, carried from the top through the config stage to the counter
   typedef struct packed
   {
      logic        enable;
      timer_mode_e mode;
   } timer_ctrl_t;

   // why the pipeline is reloading this cycle
   typedef enum logic [1:0]
   {
      // normal running
      RLD_NONE    = 2'd0,
      // first cycle after async reset release
      RLD_RESET   = 2'd1,
      // restart requested by the user
      RLD_RESTART = 2'd2
   } reload_cause_e;

endpackage

`default_nettype wire

// File: cs_strobe/cs_strobe_gen.sv
// carry-save strobe generator, emits one high cycle every divisor_i+1 cycles
// divisor_i and reload_i should come straight from flops to keep the cycle short
`timescale 1ns/1ns
`default_nettype none

module cs_strobe_gen
#(
   // must be at least 2, the carry register is one bit narrower
   parameter int DIV_WIDTH = 8
)
(
   input  wire logic                 clk_i,
   input  wire logic                 rst_n_i,
   input  wire logic [DIV_WIDTH-1:0] divisor_i,
   input  wire logic                 reload_i,
   output logic                      strobe_o
);

   // counter state in carry-save form
   // value = sum_r + (carry_r << 1)
   logic [DIV_WIDTH-1:0] sum_r;
   logic [DIV_WIDTH-2:0] carry_r;

   // next-state terms
   logic [DIV_WIDTH-1:0] add_b;
   logic [DIV_WIDTH-1:0] sum_cmp;
   logic [DIV_WIDTH-1:0] sum_nxt;
   logic [DIV_WIDTH-2:0] carry_raw;
   logic [DIV_WIDTH-2:0] carry_nxt;

   logic strobe_n;
   logic new_val;
   logic strobe_r;

   // second operand of the half-adder row
   // bit 0 gets the constant one of the increment, the rest take the shifted carries
   assign add_b = {carry_r, 1'b1};

   // counter has reached -1 once every sum bit is set
   // for an increment-only carry-save counter the carries need not be looked at,
   // which keeps this a single and-reduce deep
   assign strobe_n = &sum_r;

   // load a fresh start value on a strobe or on a reload
   // the divisor is only sampled here, so a change lands exactly at a strobe
   assign new_val = reload_i | strobe_n;

   // complement of the half-adder sum
   assign sum_cmp = ~(sum_r ^ add_b);

   // inverting select between the running sum and the divisor
   // the inversion turns sum_cmp back into the true sum, and turns
   // the divisor into its complement, which is the start value we want
   always_comb
   begin
      if (new_val)
         sum_nxt = ~divisor_i;
      else
         sum_nxt = ~sum_cmp;
   end

   // half-adder carries
   // the top carry falls off the end since the counter is modulo 2**DIV_WIDTH
   assign carry_raw = sum_r[DIV_WIDTH-2:0] & add_b[DIV_WIDTH-2:0];

   // carries are dropped on a strobe or a reload
   always_comb
   begin
      if (strobe_n || reload_i)
         carry_nxt = '0;
      else
         carry_nxt = carry_raw;
   end

   // the sum register takes its start value from each reload
   // including the one that follows reset release
   always_ff @(posedge clk_i)
   begin
      sum_r <= sum_nxt;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         carry_r <= '0;
      else
         carry_r <= carry_nxt;
   end

   // output flop
   // nothing is reported while a reload is in progress, the counter is being
   // re-seeded that cycle and the sum may not hold a real value yet
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         strobe_r <= 1'b0;
      else
         strobe_r <= strobe_n & ~reload_i;
   end

   assign strobe_o = strobe_r;

endmodule

`default_nettype wire

// File: source/tick_counter.sv
// last pipeline stage, counts generator strobes up to a limit
// pulses expire_o on the wrap and latches done_o in one-shot mode
`timescale 1ns/1ns
`default_nettype none

module tick_counter
#(
   parameter int CNT_WIDTH = 8
)
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_n_i,
   input  wire logic                      strobe_i,
   input  wire logic [CNT_WIDTH-1:0]      limit_i,
   input  tick_timer_pkg::timer_ctrl_t    ctrl_i,
   input  tick_timer_pkg::reload_cause_e  reload_cause_i,
   output logic      [CNT_WIDTH-1:0]      count_o,
   output logic                           expire_o,
   output logic                           done_o
);

   logic [CNT_WIDTH-1:0] count_q;
   logic                 expire_q;
   logic                 done_q;

   logic clear;
   logic tick;
   logic at_limit;
   logic oneshot;

   // any reload, whatever its cause, starts the count over
   always_comb
   begin
      case (reload_cause_i)
         tick_timer_pkg::RLD_RESET,
         tick_timer_pkg::RLD_RESTART: clear = 1'b1;
         default:                     clear = 1'b0;
      endcase
   end

   // a strobe only counts while enabled and not already finished
   assign tick = strobe_i & ctrl_i.enable & ~done_q;

   // >= rather than == so a limit lowered below the count still wraps
   assign at_limit = (count_q >= limit_i);

   assign oneshot = (ctrl_i.mode == tick_timer_pkg::TMR_ONESHOT);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         count_q  <= '0;
         expire_q <= 1'b0;
         done_q   <= 1'b0;
      end
      else if (clear)
      begin
         // cleared on the same edge the generator reloads
         count_q  <= '0;
         expire_q <= 1'b0;
         done_q   <= 1'b0;
      end
      else
      begin
         // expiry is a single-cycle pulse
         expire_q <= 1'b0;
         if (tick)
         begin
            if (at_limit)
            begin
               // wrap and flag expiry together
               count_q  <= '0;
               expire_q <= 1'b1;
               // one-shot holds here until the next restart
               if (oneshot)
                  done_q <= 1'b1;
            end
            else
            begin
               count_q <= count_q + 1'b1;
            end
         end
      end
   end

   assign count_o  = count_q;
   assign expire_o = expire_q;
   assign done_o   = done_q;

endmodule

`default_nettype wire

// File: source/tick_timer_top.sv
// programmable tick timer, config register stage -> carry-save strobe -> tick counter
// set DIV_WIDTH (at least 2) and CNT_WIDTH here, they are passed down to the stages
`timescale 1ns/1ns
`default_nettype none

module tick_timer_top
#(
   parameter int DIV_WIDTH = 8,
   parameter int CNT_WIDTH = 8
)
(
   input  wire logic                      clk_i,
   input  wire logic                      rst_n_i,
   input  wire logic [DIV_WIDTH-1:0]      divisor_i,
   input  wire logic [CNT_WIDTH-1:0]      limit_i,
   input  tick_timer_pkg::timer_ctrl_t    ctrl_i,
   input  wire logic                      restart_i,
   output logic                           strobe_o,
   output logic      [CNT_WIDTH-1:0]      count_o,
   output logic                           expire_o,
   output logic                           done_o
);

   // registered configuration
   logic [DIV_WIDTH-1:0]             divisor_r;
   logic [CNT_WIDTH-1:0]             limit_r;
   tick_timer_pkg::timer_ctrl_t      ctrl_r;
   logic                             reload_r;
   tick_timer_pkg::reload_cause_e    reload_cause_r;

   // generator output, also feeds the counter
   logic strobe_r;

   timer_cfg_stage
   #(
      .DIV_WIDTH (DIV_WIDTH),
      .CNT_WIDTH (CNT_WIDTH)
   )
   timer_cfg_stage_inst
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .divisor_i      (divisor_i),
      .limit_i        (limit_i),
      .ctrl_i         (ctrl_i),
      .restart_i      (restart_i),
      .divisor_o      (divisor_r),
      .limit_o        (limit_r),
      .ctrl_o         (ctrl_r),
      .reload_o       (reload_r),
      .reload_cause_o (reload_cause_r)
   );

   cs_strobe_gen
   #(
      .DIV_WIDTH (DIV_WIDTH)
   )
   cs_strobe_gen_inst
   (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .divisor_i (divisor_r),
      .reload_i  (reload_r),
      .strobe_o  (strobe_r)
   );

   tick_counter
   #(
      .CNT_WIDTH (CNT_WIDTH)
   )
   tick_counter_inst
   (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .strobe_i       (strobe_r),
      .limit_i        (limit_r),
      .ctrl_i         (ctrl_r),
      .reload_cause_i (reload_cause_r),
      .count_o        (count_o),
      .expire_o       (expire_o),
      .done_o         (done_o)
   );

   assign strobe_o = strobe_r;

endmodule

`default_nettype wire

// File: source/timer_cfg_stage.sv
// first pipeline stage of the tick timer
// registers all configuration so the strobe generator only ever sees flop outputs,
// and turns reset release and restart requests into a one-cycle synchronous reload
`timescale 1ns/1ns
`default_nettype none

module timer_cfg_stage
#(
   parameter int DIV_WIDTH = 8,
   parameter int CNT_WIDTH = 8
)
(
   input  wire logic                          clk_i,
   input  wire logic                          rst_n_i,
   input  wire logic [DIV_WIDTH-1:0]          divisor_i,
   input  wire logic [CNT_WIDTH-1:0]          limit_i,
   input  tick_timer_pkg::timer_ctrl_t        ctrl_i,
   input  wire logic                          restart_i,
   output logic      [DIV_WIDTH-1:0]          divisor_o,
   output logic      [CNT_WIDTH-1:0]          limit_o,
   output tick_timer_pkg::timer_ctrl_t        ctrl_o,
   output logic                               reload_o,
   output tick_timer_pkg::reload_cause_e      reload_cause_o
);

   logic [DIV_WIDTH-1:0]             divisor_q;
   logic [CNT_WIDTH-1:0]             limit_q;
   tick_timer_pkg::timer_ctrl_t      ctrl_q;
   logic                             reload_q;
   tick_timer_pkg::reload_cause_e    cause_q;
   tick_timer_pkg::reload_cause_e    cause_nxt;

   // configuration capture, one cycle of latency on everything
   // the first reload after reset release loads a zero divisor
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         divisor_q <= '0;
         limit_q   <= '0;
         ctrl_q    <= '{enable: 1'b0, mode: tick_timer_pkg::TMR_PERIODIC};
      end
      else
      begin
         divisor_q <= divisor_i;
         limit_q   <= limit_i;
         ctrl_q    <= ctrl_i;
      end
   end

   // cause of the next reload, restart wins over nothing
   always_comb
   begin
      if (restart_i)
         cause_nxt = tick_timer_pkg::RLD_RESTART;
      else
         cause_nxt = tick_timer_pkg::RLD_NONE;
   end

   // reload sits high through reset and for the first cycle after release,
   // so the sum register of the generator is loaded on the first edge
   // after that it is just the registered restart request
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         reload_q <= 1'b1;
         cause_q  <= tick_timer_pkg::RLD_RESET;
      end
      else
      begin
         reload_q <= restart_i;
         cause_q  <= cause_nxt;
      end
   end

   assign divisor_o      = divisor_q;
   assign limit_o        = limit_q;
   assign ctrl_o         = ctrl_q;
   assign reload_o       = reload_q;
   assign reload_cause_o = cause_q;

endmodule

`default_nettype wire

// File: src.f
+incdir+bench
common/tick_timer_pkg.sv
source/timer_cfg_stage.sv
cs_strobe/cs_strobe_gen.sv
source/tick_counter.sv
source/tick_timer_top.sv
bench/tick_timer_tb.sv
